//--- include/tex_params.svh
/*
 * Sizing of the texel data stage.
 * Cache and memory address widths and the cache line format.
 */
`ifndef TEX_PARAMS_SVH
`define TEX_PARAMS_SVH
`default_nettype none

// Cache byte address width.
`define TEX_CACHE_DEPTH 13
// Memory byte address width, destination is one bit narrower.
`define TEX_FML_DEPTH 26
// One fetched cache line.
`define TEX_LINE_BITS 256
// Byte offset bits within a 32-byte line.
`define TEX_LINE_OFS 5
`define TEX_TEXEL_BITS 16
`define TEX_FRAC_BITS 6

`default_nettype wire
`endif

//--- design/tex_pkg.sv
/*
 * Shared types of the texel data stage.
 * Fragment, downstream result and control states.
 */
`include "tex_params.svh"
`default_nettype none

package tex_pkg;

	// ------------------------------------------------
	// Fragment from the tag stage.
	// Array index 0 is texel a, index 3 is texel d.
	// ------------------------------------------------
	typedef struct packed {
		logic [`TEX_FML_DEPTH-2:0]        dadr;
		logic [3:0][`TEX_CACHE_DEPTH-1:0] tadr;
		logic [`TEX_FRAC_BITS-1:0]        x_frac;
		logic [`TEX_FRAC_BITS-1:0]        y_frac;
		logic [3:0]                       miss;
	} frag_t;

	// ------------------------------------------------
	// Result to the filter stage.
	// ------------------------------------------------
	typedef struct packed {
		logic [`TEX_FML_DEPTH-2:0]       dadr;
		logic [3:0][`TEX_TEXEL_BITS-1:0] color;
		logic [`TEX_FRAC_BITS-1:0]       x_frac;
		logic [`TEX_FRAC_BITS-1:0]       y_frac;
	} texel_out_t;

	// Control states.
	typedef enum logic [1:0] {
		RUNNING = 2'd0,
		COMMIT  = 2'd1,
		STROBE  = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- design/tex_frag_reg.sv
/*
 * Fragment register.
 * Holds the current fragment and muxes the cache read addresses.
 */
`include "tex_params.svh"
`default_nettype none
`timescale 1ns/1ps

module tex_frag_reg (
	input  wire                              sys_clk,
	input  wire                              sys_rst,

	input  wire tex_pkg::frag_t              frag_i,
	input  wire                              frag_stb_i,
	input  wire                              req_ce_i,
	input  wire                              retry_i,

	output tex_pkg::frag_t                   frag_o,
	output logic                             req_valid_o,
	output logic                             any_miss_o,
	output logic [3:0][`TEX_CACHE_DEPTH-1:0] rd_addr_o
);

	// Valid follows the input strobe whenever the register loads.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			req_valid_o <= 1'b0;
		end else if (req_ce_i) begin
			req_valid_o <= frag_stb_i;
		end
	end

	// Payload.
	always_ff @(posedge sys_clk) begin
		if (req_ce_i) begin
			frag_o <= frag_i;
		end
	end

	// ------------------------------------------------
	// Read address mux.
	// ------------------------------------------------

	// Retry re-reads the held fragment, otherwise the cache
	// looks ahead at the incoming one.
	assign rd_addr_o = retry_i ? frag_o.tadr : frag_i.tadr;

	assign any_miss_o = |frag_o.miss;

endmodule

`default_nettype wire

//--- design/tex_quad_ram.sv
/*
 * Texel cache RAM.
 * Four synchronous 16-bit read ports, one line-wide write port.
 */
`include "tex_params.svh"
`default_nettype none
`timescale 1ns/1ps

module tex_quad_ram (
	input  wire                              sys_clk,

	input  wire [3:0][`TEX_CACHE_DEPTH-1:0]  rd_addr_i,
	output logic [3:0][`TEX_TEXEL_BITS-1:0]  rd_dat_o,

	input  wire                              we_i,
	input  wire [`TEX_CACHE_DEPTH-1:0]       wr_addr_i,
	input  wire [`TEX_LINE_BITS-1:0]         wr_dat_i
);

	localparam int IDX_BITS = `TEX_CACHE_DEPTH - `TEX_LINE_OFS;
	localparam int LINES    = 1 << IDX_BITS;

	logic [`TEX_LINE_BITS-1:0] mem [0:LINES-1];

	// ------------------------------------------------
	// Write port.
	// ------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (we_i) begin
			mem[wr_addr_i[`TEX_CACHE_DEPTH-1:`TEX_LINE_OFS]] <= wr_dat_i;
		end
	end

	// ------------------------------------------------
	// Read ports.
	// ------------------------------------------------

	// Address bits 4..1 pick the texel, texel k sits at bits 16k+15..16k.
	// Bit 0 is ignored since texels are halfword aligned.
	always_ff @(posedge sys_clk) begin
		for (int p = 0; p < 4; p++) begin
			rd_dat_o[p] <= mem[rd_addr_i[p][`TEX_CACHE_DEPTH-1:`TEX_LINE_OFS]]
				[rd_addr_i[p][`TEX_LINE_OFS-1:1] * `TEX_TEXEL_BITS +: `TEX_TEXEL_BITS];
		end
	end

endmodule

`default_nettype wire

//--- design/tex_miss_tracker.sv
/*
 * Miss tracker.
 * Pending mask and selection of the next cache line to write.
 */
`include "tex_params.svh"
`default_nettype none
`timescale 1ns/1ps

module tex_miss_tracker (
	input  wire                              sys_clk,
	input  wire                              init_i,
	input  wire                              we_i,

	input  wire [3:0]                        miss_i,
	input  wire [3:0][`TEX_CACHE_DEPTH-1:0]  addr_i,

	output logic                             all_done_o,
	output logic [`TEX_CACHE_DEPTH-1:0]      wr_addr_o
);

	logic [3:0] mask;
	logic [3:0] pending;
	logic [1:0] sel;

	// A texel still needs a line if it missed and was not written yet.
	assign pending    = miss_i & mask;
	assign all_done_o = (pending == 4'b0000);

	// Lowest pending texel first, so lines are taken in a, b, c, d order.
	always_comb begin
		if (pending[0]) begin
			sel = 2'd0;
		end else if (pending[1]) begin
			sel = 2'd1;
		end else if (pending[2]) begin
			sel = 2'd2;
		end else begin
			sel = 2'd3;
		end
	end

	assign wr_addr_o = addr_i[sel];

	// ------------------------------------------------
	// Pending mask.
	// ------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (init_i) begin
			mask <= 4'b1111;
		end else if (we_i) begin
			mask[sel] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/tex_datamem_ctrl.sv
/*
 * Texel data stage control.
 * Sequences fragment accept, line commit on misses and result strobe.
 */
`default_nettype none
`timescale 1ns/1ps

module tex_datamem_ctrl (
	input  wire  sys_clk,
	input  wire  sys_rst,

	input  wire  frag_stb_i,
	output logic frag_ack_o,
	input  wire  fetch_stb_i,
	output logic fetch_ack_o,
	output logic out_stb_o,
	input  wire  out_ack_i,
	output logic busy_o,

	input  wire  req_valid_i,
	input  wire  any_miss_i,
	input  wire  all_done_i,

	output logic req_ce_o,
	output logic retry_o,
	output logic ram_we_o,
	output logic mask_init_o,
	output logic mask_we_o
);

	tex_pkg::ctrl_state_e state;
	tex_pkg::ctrl_state_e next_state;

	// Register slot is free for the next fragment.
	logic load;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tex_pkg::RUNNING;
		end else begin
			state <= next_state;
		end
	end

	// ------------------------------------------------
	// Next state and handshakes.
	// ------------------------------------------------
	always_comb begin
		next_state  = state;
		frag_ack_o  = 1'b0;
		fetch_ack_o = 1'b0;
		out_stb_o   = 1'b0;
		load        = 1'b0;
		retry_o     = 1'b0;
		ram_we_o    = 1'b0;
		mask_init_o = 1'b0;
		mask_we_o   = 1'b0;

		case (state)
			tex_pkg::RUNNING: begin
				// Mask is rearmed every cycle until a miss shows up.
				mask_init_o = 1'b1;
				if (!req_valid_i) begin
					frag_ack_o = 1'b1;
					load       = 1'b1;
				end else if (any_miss_i) begin
					next_state = tex_pkg::COMMIT;
				end else begin
					out_stb_o = 1'b1;
					if (out_ack_i) begin
						frag_ack_o = 1'b1;
						load       = 1'b1;
					end else begin
						retry_o = 1'b1;
					end
				end
			end

			tex_pkg::COMMIT: begin
				retry_o = 1'b1;
				if (all_done_i) begin
					// One more cycle so the RAM reads back the new lines.
					next_state = tex_pkg::STROBE;
				end else begin
					fetch_ack_o = 1'b1;
					ram_we_o    = fetch_stb_i;
					mask_we_o   = fetch_stb_i;
				end
			end

			tex_pkg::STROBE: begin
				out_stb_o = 1'b1;
				if (out_ack_i) begin
					frag_ack_o = 1'b1;
					load       = 1'b1;
					next_state = tex_pkg::RUNNING;
				end else begin
					retry_o = 1'b1;
				end
			end

			default: begin
				next_state = tex_pkg::RUNNING;
			end
		endcase
	end

	// Load only when a fragment arrives or a stale valid must be cleared.
	assign req_ce_o = load & (frag_stb_i | req_valid_i);

	assign busy_o = (state != tex_pkg::RUNNING);

endmodule

`default_nettype wire

//--- design/tex_datamem_top.sv
/*
 * Texel data stage top level.
 * Reads four texels per fragment and refills missing cache lines.
 */
`include "tex_params.svh"
`default_nettype none
`timescale 1ns/1ps

module tex_datamem_top (
	input  wire                         sys_clk,
	input  wire                         sys_rst,

	input  wire                         frag_stb_i,
	input  wire tex_pkg::frag_t         frag_i,
	output logic                        frag_ack_o,

	input  wire                         fetch_stb_i,
	input  wire [`TEX_LINE_BITS-1:0]    fetch_dat_i,
	output logic                        fetch_ack_o,

	output logic                        out_stb_o,
	output tex_pkg::texel_out_t         out_o,
	input  wire                         out_ack_i,

	output logic                        busy_o
);

	tex_pkg::frag_t                   frag_q;
	logic                             req_ce;
	logic                             retry;
	logic                             req_valid;
	logic                             any_miss;
	logic                             all_done;
	logic                             ram_we;
	logic                             mask_init;
	logic                             mask_we;
	logic [3:0][`TEX_CACHE_DEPTH-1:0] rd_addr;
	logic [3:0][`TEX_TEXEL_BITS-1:0]  rd_dat;
	logic [`TEX_CACHE_DEPTH-1:0]      wr_addr;

	// ------------------------------------------------
	// Control.
	// ------------------------------------------------
	tex_datamem_ctrl u_ctrl (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.frag_stb_i  (frag_stb_i),
		.frag_ack_o  (frag_ack_o),
		.fetch_stb_i (fetch_stb_i),
		.fetch_ack_o (fetch_ack_o),
		.out_stb_o   (out_stb_o),
		.out_ack_i   (out_ack_i),
		.busy_o      (busy_o),
		.req_valid_i (req_valid),
		.any_miss_i  (any_miss),
		.all_done_i  (all_done),
		.req_ce_o    (req_ce),
		.retry_o     (retry),
		.ram_we_o    (ram_we),
		.mask_init_o (mask_init),
		.mask_we_o   (mask_we)
	);

	// ------------------------------------------------
	// Datapath.
	// ------------------------------------------------
	tex_frag_reg u_frag_reg (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.frag_i      (frag_i),
		.frag_stb_i  (frag_stb_i),
		.req_ce_i    (req_ce),
		.retry_i     (retry),
		.frag_o      (frag_q),
		.req_valid_o (req_valid),
		.any_miss_o  (any_miss),
		.rd_addr_o   (rd_addr)
	);

	tex_quad_ram u_ram (
		.sys_clk   (sys_clk),
		.rd_addr_i (rd_addr),
		.rd_dat_o  (rd_dat),
		.we_i      (ram_we),
		.wr_addr_i (wr_addr),
		.wr_dat_i  (fetch_dat_i)
	);

	tex_miss_tracker u_tracker (
		.sys_clk    (sys_clk),
		.init_i     (mask_init),
		.we_i       (mask_we),
		.miss_i     (frag_q.miss),
		.addr_i     (frag_q.tadr),
		.all_done_o (all_done),
		.wr_addr_o  (wr_addr)
	);

	// Result fields come from the held fragment, colors from the RAM.
	assign out_o = tex_pkg::texel_out_t'{
		dadr:   frag_q.dadr,
		color:  rd_dat,
		x_frac: frag_q.x_frac,
		y_frac: frag_q.y_frac
	};

endmodule

`default_nettype wire

//--- bench/tex_datamem_assert.sv
/*
 * Handshake and reset checks for the texel data stage control.
 */
`default_nettype none
`timescale 1ns/1ps

module tex_datamem_assert (
	input wire sys_clk,
	input wire sys_rst,
	input wire frag_ack_i,
	input wire fetch_ack_i,
	input wire out_stb_i,
	input wire out_ack_i,
	input wire busy_i
);

	// A result that is not taken stays offered.
	out_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_stb_i && !out_ack_i |=> out_stb_i)
		else $error("out_stb_o dropped before out_ack_i");

	// Lines are only taken while a miss is being served.
	fetch_in_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fetch_ack_i |-> busy_i)
		else $error("fetch_ack_o high while busy_o is low");

	// No new fragment while a result waits.
	frag_blocked: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_stb_i && !out_ack_i |-> !frag_ack_i)
		else $error("frag_ack_o high while a result waits");

	// Control comes out of reset idle.
	reset_idle: assert property (@(posedge sys_clk)
		$past(sys_rst) && !sys_rst |-> !out_stb_i && !fetch_ack_i && !busy_i)
		else $error("control not idle after reset");

endmodule

`default_nettype wire

//--- bench/tb_tex_datamem.sv
/*
 * Testbench for the texel data stage.
 * Random fragments and fetch lines against a model cache, with back-pressure.
 */
`include "tex_params.svh"
`default_nettype none
`timescale 1ns/1ps

module tb_tex_datamem;

	localparam int IDX = `TEX_CACHE_DEPTH - `TEX_LINE_OFS;
	localparam int LINES = 1 << IDX;
	localparam int N_RAND = 300;
	localparam int MAX_CYCLES = 20000;

	logic                      sys_clk;
	logic                      sys_rst;
	logic                      frag_stb;
	tex_pkg::frag_t            frag;
	logic                      frag_ack;
	logic                      fetch_stb;
	logic [`TEX_LINE_BITS-1:0] fetch_dat;
	logic                      fetch_ack;
	logic                      out_stb;
	tex_pkg::texel_out_t       result;
	logic                      out_ack;
	logic                      busy;

	// Model cache and the traffic still to come.
	logic [`TEX_LINE_BITS-1:0] model [0:LINES-1];
	tex_pkg::frag_t            frag_q[$];
	tex_pkg::texel_out_t       exp_q[$];
	int                        miss_q[$];
	logic [`TEX_LINE_BITS-1:0] line_q[$];
	int                        errors;
	int                        results;
	int                        fetches;

	tex_datamem_top DUT (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.frag_stb_i  (frag_stb),
		.frag_i      (frag),
		.frag_ack_o  (frag_ack),
		.fetch_stb_i (fetch_stb),
		.fetch_dat_i (fetch_dat),
		.fetch_ack_o (fetch_ack),
		.out_stb_o   (out_stb),
		.out_o       (result),
		.out_ack_i   (out_ack),
		.busy_o      (busy)
	);

	bind tex_datamem_ctrl tex_datamem_assert u_assert (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.frag_ack_i  (frag_ack_o),
		.fetch_ack_i (fetch_ack_o),
		.out_stb_i   (out_stb_o),
		.out_ack_i   (out_ack_i),
		.busy_i      (busy_o)
	);

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	task automatic compare_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic require(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			$display("Check failed at %0t: %s", $time, what);
		end
	endtask

	function automatic logic [`TEX_LINE_BITS-1:0] random_line();
		logic [`TEX_LINE_BITS-1:0] l;
		for (int w = 0; w < `TEX_LINE_BITS / 32; w++) begin
			l[w*32 +: 32] = $urandom;
		end
		return l;
	endfunction

	// Line from the upper address bits, texel from bits 4..1.
	function automatic logic [15:0] texel_at(input logic [`TEX_CACHE_DEPTH-1:0] a);
		logic [`TEX_LINE_BITS-1:0] l;
		l = model[a[`TEX_CACHE_DEPTH-1:`TEX_LINE_OFS]];
		return l[a[`TEX_LINE_OFS-1:1] * 16 +: 16];
	endfunction

	// Refill lines go in a, b, c, d order, then colors are read back.
	task automatic add_fragment(input tex_pkg::frag_t f);
		tex_pkg::texel_out_t       e;
		logic [`TEX_LINE_BITS-1:0] l;
		int                        n;
		n = 0;
		for (int k = 0; k < 4; k++) begin
			if (f.miss[k]) begin
				l = random_line();
				model[f.tadr[k][`TEX_CACHE_DEPTH-1:`TEX_LINE_OFS]] = l;
				line_q.push_back(l);
				n++;
			end
		end
		e.dadr = f.dadr;
		e.x_frac = f.x_frac;
		e.y_frac = f.y_frac;
		for (int k = 0; k < 4; k++) begin
			e.color[k] = texel_at(f.tadr[k]);
		end
		frag_q.push_back(f);
		exp_q.push_back(e);
		miss_q.push_back(n);
	endtask

	// Warm-up fragments fill every line, then random traffic follows.
	task automatic build_stimulus();
		tex_pkg::frag_t f;
		for (int i = 0; i < N_RAND + LINES / 4; i++) begin
			f.dadr = (`TEX_FML_DEPTH-1)'($urandom);
			f.x_frac = `TEX_FRAC_BITS'($urandom);
			f.y_frac = `TEX_FRAC_BITS'($urandom);
			for (int k = 0; k < 4; k++) begin
				if (i < LINES / 4) begin
					f.tadr[k] = {IDX'(4 * i + k), `TEX_LINE_OFS'($urandom)};
				end else begin
					f.tadr[k] = `TEX_CACHE_DEPTH'($urandom);
				end
			end
			if (i < LINES / 4) begin
				f.miss = 4'b1111;
			end else if ($urandom_range(0, 3) == 0) begin
				f.miss = 4'($urandom_range(1, 15));
			end else begin
				f.miss = 4'b0000;
			end
			add_fragment(f);
		end
	endtask

	// ------------------------------------------------
	// Traffic loop, one pass per clock cycle.
	// ------------------------------------------------
	task automatic run_traffic();
		tex_pkg::texel_out_t e;
		tex_pkg::texel_out_t held;
		logic                held_valid;
		logic                frag_done;
		logic                fetch_done;
		int                  fetched;
		int                  cycles;
		held_valid = 1'b0;
		frag_done = 1'b0;
		fetch_done = 1'b0;
		fetched = 0;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < MAX_CYCLES) begin
			@(negedge sys_clk);
			cycles++;
			if (frag_done) frag_stb = 1'b0;
			if (fetch_done) fetch_stb = 1'b0;
			// Once offered, a word stays until it is taken.
			if (!frag_stb && frag_q.size() > 0 && $urandom_range(0, 3) != 0) begin
				frag_stb = 1'b1;
				frag = frag_q[0];
			end
			if (!fetch_stb && line_q.size() > 0 && $urandom_range(0, 3) != 0) begin
				fetch_stb = 1'b1;
				fetch_dat = line_q[0];
			end
			out_ack = ($urandom_range(0, 2) != 0);
			#1;
			frag_done = frag_stb && frag_ack;
			fetch_done = fetch_stb && fetch_ack;
			if (fetch_ack) require(busy, "fetch_ack_o high while busy_o is low");
			if (busy) require(miss_q.size() > 0 && miss_q[0] > 0, "busy_o high on a hit");
			if (held_valid) require(out_stb, "out_stb_o dropped before its result was taken");
			if (out_stb && !out_ack) require(!frag_ack, "frag_ack_o high while a result waits");
			if (out_stb && held_valid) compare_value("out_o (held)", result, held);
			if (out_stb && out_ack) begin
				e = exp_q.pop_front();
				compare_value("out_o.dadr", result.dadr, e.dadr);
				compare_value("out_o.x_frac", result.x_frac, e.x_frac);
				compare_value("out_o.y_frac", result.y_frac, e.y_frac);
				for (int k = 0; k < 4; k++) begin
					compare_value($sformatf("out_o.color[%0d]", k), result.color[k], e.color[k]);
				end
				compare_value("fetch lines taken", fetched, miss_q[0]);
				require((miss_q[0] > 0) == busy, "busy_o wrong when the result is taken");
				void'(miss_q.pop_front());
				fetched = 0;
				held_valid = 1'b0;
				results++;
			end else if (out_stb) begin
				held = result;
				held_valid = 1'b1;
			end
			if (frag_done) void'(frag_q.pop_front());
			if (fetch_done) begin
				void'(line_q.pop_front());
				fetched++;
				fetches++;
			end
		end
		if (exp_q.size() > 0) begin
			errors++;
			$display("Timeout: %0d results still missing after %0d cycles", exp_q.size(), cycles);
		end else begin
			require(line_q.size() == 0, "fetch lines left over at the end");
		end
	endtask

	initial begin
		errors = 0;
		results = 0;
		fetches = 0;
		sys_rst = 1'b1;
		frag_stb = 1'b0;
		frag = '0;
		fetch_stb = 1'b0;
		fetch_dat = '0;
		out_ack = 1'b0;
		void'($urandom(32'h1c28));
		build_stimulus();
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		#1;
		compare_value("out_stb_o", out_stb, 1'b0);
		compare_value("fetch_ack_o", fetch_ack, 1'b0);
		compare_value("busy_o", busy, 1'b0);
		compare_value("frag_ack_o", frag_ack, 1'b1);
		run_traffic();
		$display("Results %0d, fetch lines %0d, errors %0d", results, fetches, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/tex_pkg.sv
design/tex_frag_reg.sv
design/tex_quad_ram.sv
design/tex_miss_tracker.sv
design/tex_datamem_ctrl.sv
design/tex_datamem_top.sv
bench/tex_datamem_assert.sv
bench/tb_tex_datamem.sv

//--- run_sim.sh
#!/bin/sh
# Build the texel data stage testbench with Verilator and run it.
# The run passes only if the output holds the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_tex_datamem -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -F "Finished with no errors" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
